// File: common/sdp_rdma_pkg.sv
/*
  Shared constants and types for the SDP read-DMA ingress stage.
  Imported by every ingress module that needs the config or CQ entry layout.
*/
package sdp_rdma_pkg;

  // ==============================
  // memory atom geometry
  // ==============================

  // 32-byte memory atom
  localparam int atom_bits    = 5;
  // 16-bit precision packs 16 channels per atom
  localparam int atom_bits_16 = 4;

  // cube dimension fields, minus-one encoded
  localparam int dim_w        = 13;

  // request size in atoms minus one
  localparam int req_size_w   = 15;

  // atom-granular address, stride and low base
  localparam int stride_w     = 32 - atom_bits;

  typedef logic [req_size_w-1:0] req_size_t;

  // processing precision
  typedef enum logic [1:0] {
    prec_int8  = 2'd0,
    prec_int16 = 2'd1,
    prec_fp16  = 2'd2
  } prec_e;

  // ==============================
  // register config
  // ==============================

  // held stable for the whole operation
  typedef struct packed {
    logic [dim_w-1:0]    channel;
    logic [dim_w-1:0]    height;
    logic [dim_w-1:0]    width;
    prec_e               precision;
    // 0 = per kernel, 1 = per element
    logic                data_mode;
    // 0 = one byte per element
    logic                data_size;
    // 2 = both operands
    logic [1:0]          data_use;
    logic [31:0]         base_addr_high;
    logic [stride_w-1:0] base_addr_low;
    logic [stride_w-1:0] line_stride;
    logic [stride_w-1:0] surf_stride;
  } rdma_cfg_t;

  // ==============================
  // context queue
  // ==============================

  // one entry per DMA request, consumed by the egress side
  typedef struct packed {
    logic      cube_end;
    req_size_t size;
  } cq_entry_t;

endpackage

// File: design/rdma_stall_cnt.sv
/*
  32-bit performance counter of stalled request cycles.
  Wraps on overflow; clear and count only take effect while enabled.
*/
module rdma_stall_cnt (
  input  logic        nvdla_core_clk,
  input  logic        nvdla_core_rstn,
  input  logic        clr,
  input  logic        en,
  input  logic        stall,
  output logic [31:0] count
);

  logic [31:0] count_q;
  logic [31:0] count_nxt;

  // clear wins over increment
  always_comb begin
    if (clr) begin
      count_nxt = '0;
    end else if (stall) begin
      count_nxt = count_q + 32'd1;
    end else begin
      count_nxt = count_q;
    end
  end

  // frozen while disabled, clear included
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_q <= '0;
    end else if (en) begin
      count_q <= count_nxt;
    end
  end

  assign count = count_q;

endmodule

// File: design/rdma_ig/rdma_req_size.sv
/*
  Request size calculator for the read-DMA ingress stage.
  Combinational; gives the request size in atoms minus one and the last
  channel-atom index of the cube.
*/
module rdma_req_size (
  input  sdp_rdma_pkg::rdma_cfg_t         cfg,
  output sdp_rdma_pkg::req_size_t         req_size,
  output logic [sdp_rdma_pkg::dim_w-1:0]  surf_last_idx
);
  import sdp_rdma_pkg::*;

  logic      is_int8;
  logic      size_1byte;
  logic      use_both;
  logic      per_kernel;
  logic      pack_1x1;
  logic      straight;
  logic [1:0] k_shift;
  req_size_t  unit_cnt;
  req_size_t  k_minus1;

  // ==============================
  // config decode
  // ==============================

  assign is_int8    = (cfg.precision == prec_int8);
  assign size_1byte = (cfg.data_size == 1'b0);
  assign use_both   = (cfg.data_use == 2'd2);
  assign per_kernel = (cfg.data_mode == 1'b0);
  assign pack_1x1   = (cfg.width == '0) && (cfg.height == '0);

  // one request for the whole surface stack
  assign straight = per_kernel | pack_1x1;

  // channel atoms minus one
  // int8 packs 32 channels per atom, 16-bit types pack 16
  assign surf_last_idx = is_int8 ? (cfg.channel >> atom_bits)
                                 : (cfg.channel >> atom_bits_16);

  // ==============================
  // bytes per element -> atom multiplier
  // ==============================

  // k = 1 << k_shift
  //   int8  1B single  1B/elem  x1
  //   int8  1B both    2B/elem  x2
  //   int8  2B single  2B/elem  x2
  //   int8  2B both    4B/elem  x4
  //   16b   single              x1
  //   16b   both                x2
  always_comb begin
    if (is_int8) begin
      if (use_both) begin
        k_shift = size_1byte ? 2'd1 : 2'd2;
      end else begin
        k_shift = size_1byte ? 2'd0 : 2'd1;
      end
    end else begin
      k_shift = use_both ? 2'd1 : 2'd0;
    end
  end

  // ==============================
  // request size
  // ==============================

  // straight mode scales the channel atoms, line mode scales the width
  assign unit_cnt = straight ? req_size_t'(surf_last_idx) : req_size_t'(cfg.width);

  // low fill for the extra atoms of each element
  assign k_minus1 = (req_size_t'(1) << k_shift) - req_size_t'(1);

  // (n + 1) * k - 1
  assign req_size = (unit_cnt << k_shift) + k_minus1;

endmodule

// File: design/rdma_ig/rdma_cube_walk.sv
/*
  Cube walker for the read-DMA ingress stage.
  Tracks the active flag and the channel-atom / line counters, and flags
  the surface and cube boundaries of the current step.
*/
module rdma_cube_walk (
  input  logic                            nvdla_core_clk,
  input  logic                            nvdla_core_rstn,
  input  logic                            op_load,
  input  logic                            accept,
  input  sdp_rdma_pkg::rdma_cfg_t         cfg,
  input  logic [sdp_rdma_pkg::dim_w-1:0]  surf_last_idx,
  output logic                            active,
  output logic                            surf_end,
  output logic                            cube_end
);
  import sdp_rdma_pkg::*;

  logic             per_kernel;
  logic             pack_1x1;
  logic             is_last_c;
  logic             is_last_h;
  logic             op_done;
  logic [dim_w-1:0] count_c;
  logic [dim_w-1:0] count_h;

  // ==============================
  // mode decode
  // ==============================

  assign per_kernel = (cfg.data_mode == 1'b0);
  // 1x1 pack, whole cube in one request
  assign pack_1x1   = (cfg.width == '0) && (cfg.height == '0);

  assign is_last_c = (count_c == surf_last_idx);
  assign is_last_h = (count_h == cfg.height);

  // every step is a full line, so surface end is just the last line
  assign surf_end = pack_1x1 | per_kernel | is_last_h;
  assign cube_end = pack_1x1 | per_kernel | (surf_end & is_last_c);

  assign op_done = accept & cube_end;

  // ==============================
  // active flag
  // ==============================

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      active <= 1'b0;
    end else if (op_load) begin
      active <= 1'b1;
    end else if (op_done) begin
      active <= 1'b0;
    end
  end

  // ==============================
  // counters
  // ==============================

  // channel atoms, outer loop
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
    end else if (accept) begin
      if (cube_end) begin
        count_c <= '0;
      end else if (surf_end) begin
        count_c <= count_c + 1'b1;
      end
    end
  end

  // lines, inner loop
  // wraps at surface end, which also covers cube end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_h <= '0;
    end else if (accept) begin
      if (surf_end) begin
        count_h <= '0;
      end else begin
        count_h <= count_h + 1'b1;
      end
    end
  end

endmodule

// File: design/rdma_ig/rdma_addr_gen.sv
/*
  Request address generator for the read-DMA ingress stage.
  Steps line and surface base registers in atom units on each accept.
*/
module rdma_addr_gen #(
  parameter int mem_addr_w = 64
) (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  logic                     op_load,
  input  logic                     accept,
  input  logic                     surf_end,
  input  sdp_rdma_pkg::rdma_cfg_t  cfg,
  output logic [mem_addr_w-1:0]    req_addr
);
  import sdp_rdma_pkg::*;

  // atom-granular address width
  localparam int addr_w = mem_addr_w - atom_bits;

  logic [32+stride_w-1:0] base_full;
  logic [addr_w-1:0]      cfg_base;
  logic [addr_w-1:0]      line_step;
  logic [addr_w-1:0]      surf_step;
  logic [addr_w-1:0]      base_line;
  logic [addr_w-1:0]      base_surf;
  logic [addr_w-1:0]      surf_next;

  // ==============================
  // config address
  // ==============================

  // high word only matters above 32-bit addressing
  // 64-bit takes {high, low}, 32-bit keeps low only
  assign base_full = {cfg.base_addr_high, cfg.base_addr_low};
  assign cfg_base  = base_full[addr_w-1:0];

  // strides are unsigned atom counts
  assign line_step = addr_w'(cfg.line_stride);
  assign surf_step = addr_w'(cfg.surf_stride);

  // start of the next channel-atom surface
  assign surf_next = base_surf + surf_step;

  // ==============================
  // base registers
  // ==============================

  // line base, current request
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_line <= '0;
    end else if (op_load) begin
      base_line <= cfg_base;
    end else if (accept) begin
      if (surf_end) begin
        base_line <= surf_next;
      end else begin
        base_line <= base_line + line_step;
      end
    end
  end

  // surface base, first line of current surface
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_surf <= '0;
    end else if (op_load) begin
      base_surf <= cfg_base;
    end else if (accept && surf_end) begin
      base_surf <= surf_next;
    end
  end

  // byte address, atom aligned
  assign req_addr = {base_line, {atom_bits{1'b0}}};

endmodule

// File: design/rdma_ig/sdp_rdma_ig.sv
/*
  Top of the SDP read-DMA ingress command generator.
  Walks the feature cube after op_load and issues one DMA read plus one
  context-queue entry per step; also keeps the DMA stall counter.
*/
module sdp_rdma_ig #(
  parameter int mem_addr_w = 64
) (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      op_load,
  input  logic                      op_en,
  input  logic                      perf_dma_en,
  input  sdp_rdma_pkg::rdma_cfg_t   cfg,
  // dma read request
  output logic                      dma_rd_req_vld,
  input  logic                      dma_rd_req_rdy,
  output logic [mem_addr_w-1:0]     dma_rd_req_addr,
  output sdp_rdma_pkg::req_size_t   dma_rd_req_size,
  // context queue push
  output logic                      cq_pvld,
  input  logic                      cq_prdy,
  output sdp_rdma_pkg::cq_entry_t   cq_pd,
  // perf
  output logic [31:0]               rdma_stall
);
  import sdp_rdma_pkg::*;

  logic             active;
  logic             accept;
  logic             surf_end;
  logic             cube_end;
  logic [dim_w-1:0] surf_last_idx;
  req_size_t        req_size;

  // ==============================
  // handshake
  // ==============================

  // each side only sees valid when the other one is ready
  assign dma_rd_req_vld = active & cq_prdy;
  assign cq_pvld        = active & dma_rd_req_rdy;

  // dma and cq take the step in the same cycle
  assign accept = dma_rd_req_vld & dma_rd_req_rdy;

  // request payload
  assign dma_rd_req_size = req_size;

  // cq entry mirrors the request size
  assign cq_pd.cube_end = cube_end;
  assign cq_pd.size     = req_size;

  // ==============================
  // sub-blocks
  // ==============================

  rdma_req_size u_req_size (
    .cfg           (cfg),
    .req_size      (req_size),
    .surf_last_idx (surf_last_idx)
  );

  rdma_cube_walk u_cube_walk (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .accept          (accept),
    .cfg             (cfg),
    .surf_last_idx   (surf_last_idx),
    .active          (active),
    .surf_end        (surf_end),
    .cube_end        (cube_end)
  );

  rdma_addr_gen #(
    .mem_addr_w (mem_addr_w)
  ) u_addr_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .accept          (accept),
    .surf_end        (surf_end),
    .cfg             (cfg),
    .req_addr        (dma_rd_req_addr)
  );

  // stalled = offered to dma but not taken
  rdma_stall_cnt u_stall_cnt (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .clr             (op_load),
    .en              (op_en & perf_dma_en),
    .stall           (dma_rd_req_vld & ~dma_rd_req_rdy),
    .count           (rdma_stall)
  );

endmodule

// File: sim/sdp_rdma_ig_checker.sv
/*
  Concurrent assertions on the ingress top handshake and stall counter.
  Bound to sdp_rdma_ig from the testbench.
*/
module sdp_rdma_ig_checker (
  input logic                     nvdla_core_clk,
  input logic                     nvdla_core_rstn,
  input logic                     op_en,
  input logic                     perf_dma_en,
  input logic                     dma_rd_req_vld,
  input logic                     dma_rd_req_rdy,
  input sdp_rdma_pkg::req_size_t  dma_rd_req_size,
  input logic                     cq_pvld,
  input logic                     cq_prdy,
  input sdp_rdma_pkg::cq_entry_t  cq_pd,
  input logic [31:0]              rdma_stall
);
  import sdp_rdma_pkg::*;

  // cq push and dma request are taken together
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (cq_pvld && cq_prdy) == (dma_rd_req_vld && dma_rd_req_rdy))
    else $error("cq accept and dma accept disagree");

  // request and cq entry held while dma side stalls
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dma_rd_req_vld && !dma_rd_req_rdy |=> $stable(dma_rd_req_size) && $stable(cq_pd))
    else $error("request or cq entry changed while not accepted");

  // counter frozen while perf is off
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(op_en && perf_dma_en) |=> $stable(rdma_stall))
    else $error("stall counter moved while perf disabled");

endmodule

// File: sim/tb_sdp_rdma_ig.sv
/*
  Table-driven testbench for the SDP read-DMA ingress stage.
  Each row loads one cube, drives random ready and checks every request.
*/
module tb_sdp_rdma_ig;
  import sdp_rdma_pkg::*;

  typedef struct {
    rdma_cfg_t cfg;
    int        prob;
    bit        perf;
    int        reqs;
  } row_t;

  logic        nvdla_core_clk;
  logic        nvdla_core_rstn;
  logic        op_load;
  logic        op_en;
  logic        perf_dma_en;
  rdma_cfg_t   cfg;
  logic        dma_rd_req_vld;
  logic        dma_rd_req_rdy;
  logic [63:0] dma_rd_req_addr;
  req_size_t   dma_rd_req_size;
  logic        cq_pvld;
  logic        cq_prdy;
  cq_entry_t   cq_pd;
  logic [31:0] rdma_stall;

  row_t        rows[$];
  logic [63:0] exp_addr[$];
  int          exp_size[$];
  bit          exp_end[$];
  logic [31:0] rng_state;
  int          error_cnt;
  int          cycle_cnt;
  int          cycle_limit;

  sdp_rdma_ig #(
    .mem_addr_w (64)
  ) u_sdp_rdma_ig (.*);

  bind sdp_rdma_ig sdp_rdma_ig_checker u_checker (.*);

  always #5 nvdla_core_clk = ~nvdla_core_clk;

  // run limit from the table length
  always @(posedge nvdla_core_clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  // ==============================
  // helpers
  // ==============================

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_ready(input int prob, output logic rdy);
    rng_state = xorshift(rng_state);
    rdy = (rng_state % 100) < prob;
  endtask

  // fixed base and strides, cube shape per row
  task automatic add_row(input prec_e prec, input bit mode, input bit dsize,
                         input logic [1:0] duse, input int ch, input int h, input int w,
                         input int prob, input bit perf, input int reqs);
    row_t r;
    r.cfg = '0;
    r.cfg.precision      = prec;
    r.cfg.data_mode      = mode;
    r.cfg.data_size      = dsize;
    r.cfg.data_use       = duse;
    r.cfg.channel        = ch;
    r.cfg.height         = h;
    r.cfg.width          = w;
    r.cfg.base_addr_high = 32'h0000_0001;
    r.cfg.base_addr_low  = 27'h000_0100;
    r.cfg.line_stride    = 27'h000_0040;
    r.cfg.surf_stride    = 27'h000_0400;
    r.prob = prob;
    r.perf = perf;
    r.reqs = reqs;
    rows.push_back(r);
  endtask

  // atoms per element
  function automatic int k_mult(input rdma_cfg_t c);
    if (c.precision == prec_int8) begin
      if (c.data_size == 1'b0 && c.data_use != 2'd2) return 1;
      if (c.data_size == 1'b0 || c.data_use != 2'd2) return 2;
      return 4;
    end
    return (c.data_use == 2'd2) ? 2 : 1;
  endfunction

  // reference request sequence, h inner and c outer
  task automatic build_expected(input rdma_cfg_t c);
    int          k;
    int          last_c;
    logic [63:0] base;
    exp_addr.delete();
    exp_size.delete();
    exp_end.delete();
    k      = k_mult(c);
    last_c = (c.precision == prec_int8) ? (c.channel >> 5) : (c.channel >> 4);
    base   = {5'b0, c.base_addr_high, c.base_addr_low};
    if (c.data_mode == 1'b0 || (c.width == 0 && c.height == 0)) begin
      exp_addr.push_back(base << 5);
      exp_size.push_back(last_c * k + k - 1);
      exp_end.push_back(1'b1);
    end else begin
      for (int ci = 0; ci <= last_c; ci++) begin
        for (int hi = 0; hi <= c.height; hi++) begin
          exp_addr.push_back((base + ci * c.surf_stride + hi * c.line_stride) << 5);
          exp_size.push_back(c.width * k + k - 1);
          exp_end.push_back(ci == last_c && hi == c.height);
        end
      end
    end
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] got_v);
    if (got_v !== exp_v) begin
      $display("Error at %0t: %s expected %0h got %0h", $time, name, exp_v, got_v);
      error_cnt++;
    end
  endtask

  // ==============================
  // one cube per row
  // ==============================

  task automatic run_row(input int r);
    int          idx;
    int          stall_exp;
    int          errs_before;
    logic [31:0] stall_before;
    logic        d_rdy;
    logic        c_rdy;
    errs_before = error_cnt;
    build_expected(rows[r].cfg);
    if (exp_addr.size() != rows[r].reqs) begin
      $display("row %0d: model gives %0d requests but table expects %0d",
               r, exp_addr.size(), rows[r].reqs);
      error_cnt++;
    end
    // op_load pulse with both sides idle
    @(posedge nvdla_core_clk);
    #1;
    stall_before   = rdma_stall;
    cfg            = rows[r].cfg;
    op_en          = 1'b1;
    perf_dma_en    = rows[r].perf;
    dma_rd_req_rdy = 1'b0;
    cq_prdy        = 1'b0;
    op_load        = 1'b1;
    @(posedge nvdla_core_clk);
    #1;
    op_load   = 1'b0;
    idx       = 0;
    stall_exp = 0;
    while (idx < exp_addr.size()) begin
      draw_ready(rows[r].prob, d_rdy);
      draw_ready(rows[r].prob, c_rdy);
      dma_rd_req_rdy = d_rdy;
      cq_prdy        = c_rdy;
      #3;
      compare_value("dma_rd_req_vld", c_rdy, dma_rd_req_vld);
      compare_value("cq_pvld", d_rdy, cq_pvld);
      // offered content must match the pending step, held or not
      if (d_rdy || c_rdy) begin
        compare_value("dma_rd_req_addr", exp_addr[idx], dma_rd_req_addr);
        compare_value("dma_rd_req_size", exp_size[idx], dma_rd_req_size);
        compare_value("cq_pd.size", exp_size[idx], cq_pd.size);
        compare_value("cq_pd.cube_end", exp_end[idx], cq_pd.cube_end);
      end
      if (c_rdy && !d_rdy) stall_exp++;
      if (c_rdy && d_rdy) idx++;
      @(posedge nvdla_core_clk);
      #1;
    end
    // idle again after the cube-end accept
    dma_rd_req_rdy = 1'b1;
    cq_prdy        = 1'b1;
    #3;
    compare_value("dma_rd_req_vld", 1'b0, dma_rd_req_vld);
    compare_value("cq_pvld", 1'b0, cq_pvld);
    compare_value("rdma_stall", rows[r].perf ? stall_exp : stall_before, rdma_stall);
    $display("row %0d: %0d requests, stall %0d, %0d errors",
             r, idx, rdma_stall, error_cnt - errs_before);
  endtask

  // ==============================
  // main
  // ==============================

  initial begin
    nvdla_core_clk  = 1'b0;
    nvdla_core_rstn = 1'b0;
    op_load         = 1'b0;
    op_en           = 1'b0;
    perf_dma_en     = 1'b0;
    cfg             = '0;
    dma_rd_req_rdy  = 1'b0;
    cq_prdy         = 1'b0;
    rng_state       = 32'd97048;
    error_cnt       = 0;
    cycle_cnt       = 0;
    //       prec        mode sz use ch  h  w  rdy perf reqs
    add_row(prec_int8,  1, 0, 0, 63, 2, 7, 100, 1, 6);
    add_row(prec_int8,  1, 0, 0, 63, 2, 7,  60, 1, 6);
    add_row(prec_int8,  1, 0, 0, 63, 2, 7,  60, 0, 6);
    add_row(prec_int8,  0, 0, 0, 95, 3, 4, 100, 1, 1);
    add_row(prec_int8,  0, 0, 2, 95, 3, 4, 100, 1, 1);
    add_row(prec_int8,  0, 1, 0, 95, 3, 4, 100, 1, 1);
    add_row(prec_int8,  0, 1, 2, 95, 3, 4, 100, 1, 1);
    add_row(prec_int16, 0, 0, 0, 47, 3, 4, 100, 1, 1);
    add_row(prec_int16, 0, 0, 2, 47, 3, 4, 100, 1, 1);
    add_row(prec_int16, 1, 0, 2, 47, 0, 0, 100, 1, 1);
    add_row(prec_int8,  1, 1, 2, 63, 0, 0, 100, 1, 1);
    add_row(prec_fp16,  1, 0, 0, 31, 1, 3,  70, 1, 4);
    cycle_limit = 200;
    foreach (rows[i]) cycle_limit += rows[i].reqs * 8;
    // reset for two cycles
    repeat (2) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;
    dma_rd_req_rdy  = 1'b1;
    cq_prdy         = 1'b1;
    #3;
    compare_value("dma_rd_req_vld", 1'b0, dma_rd_req_vld);
    compare_value("cq_pvld", 1'b0, cq_pvld);
    compare_value("rdma_stall", 32'd0, rdma_stall);
    foreach (rows[i]) run_row(i);
    $display("rows %0d, errors %0d", rows.size(), error_cnt);
    if (error_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
common/sdp_rdma_pkg.sv
design/rdma_stall_cnt.sv
design/rdma_ig/rdma_req_size.sv
design/rdma_ig/rdma_cube_walk.sv
design/rdma_ig/rdma_addr_gen.sv
design/rdma_ig/sdp_rdma_ig.sv
sim/sdp_rdma_ig_checker.sv
sim/tb_sdp_rdma_ig.sv

// File: Bender.yml
package:
  name: sdp_rdma_ig

sources:
  - files:
      - common/sdp_rdma_pkg.sv
      - design/rdma_stall_cnt.sv
      - design/rdma_ig/rdma_req_size.sv
      - design/rdma_ig/rdma_cube_walk.sv
      - design/rdma_ig/rdma_addr_gen.sv
      - design/rdma_ig/sdp_rdma_ig.sv
  - target: simulation
    files:
      - sim/sdp_rdma_ig_checker.sv
      - sim/tb_sdp_rdma_ig.sv
